// ==== tb.f ====
+incdir+verilog
verilog/trap_pkg.sv
verilog/trap_if.sv
verilog/csr_file.sv
verilog/irq_prioritizer.sv
verilog/trap_dispatch.sv
verilog/trap_unit.sv
dv/trap_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= trap_unit_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass if the log holds the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/trap_unit_tb.sv ====
/*
 * Trap unit testbench.
 * Directed tests for CSR access, synchronous traps, MRET and the
 * priority and masking of external interrupts.
 */
`default_nettype none
`include "trap_settings.svh"

module trap_unit_tb;

    // Bound on any wait for a redirect.
    localparam int WAIT_LIMIT = 20;
    // Cycles watched for a redirect that must not come.
    localparam int QUIET_CYCLES = 8;

    logic                        clk;
    logic                        rst;
    trap_pkg::csr_addr_e         csr_addr;
    logic                        csr_we;
    trap_pkg::xlen_t             csr_wdata;
    trap_pkg::xlen_t             csr_rdata;
    logic                        csr_exists;
    logic                        csr_rdonly;
    logic [`TRAP_IRQ_HI:`TRAP_IRQ_LO] irq;
    logic                        insn_valid;
    trap_pkg::xlen_t             insn_pc;
    logic                        trap_valid;
    trap_pkg::trap_cause_t       trap_cause;
    trap_pkg::xlen_t             trap_pc;
    logic                        ret;
    logic                        redirect;
    trap_pkg::xlen_t             redirect_pc;

    int value_errors;
    int timeout_errors;
    // Trap vector and mepc expected by later tests.
    trap_pkg::xlen_t tvec_exp;
    trap_pkg::xlen_t mepc_exp;

    trap_unit #(
        .hartid (32'd5)
    ) dut_i (
        .clk         (clk),
        .rst         (rst),
        .csr_addr    (csr_addr),
        .csr_we      (csr_we),
        .csr_wdata   (csr_wdata),
        .csr_rdata   (csr_rdata),
        .csr_exists  (csr_exists),
        .csr_rdonly  (csr_rdonly),
        .irq         (irq),
        .insn_valid  (insn_valid),
        .insn_pc     (insn_pc),
        .trap_valid  (trap_valid),
        .trap_cause  (trap_cause),
        .trap_pc     (trap_pc),
        .ret         (ret),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Move to the drive point just after the next rising edge.
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic check_word(input string what, input trap_pkg::xlen_t got,
                              input trap_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
            value_errors++;
        end
    endtask

    // mstatus word with only MIE and MPIE.
    function automatic trap_pkg::xlen_t mstatus_word(input logic mie, input logic mpie);
        trap_pkg::xlen_t w;
        w = '0;
        w[`TRAP_MSTATUS_MIE_BIT] = mie;
        w[`TRAP_MSTATUS_MPIE_BIT] = mpie;
        return w;
    endfunction

    // Lowest enabled raised line or zero.
    function automatic trap_pkg::cause_t lowest_enabled(input logic [15:0] lines,
                                                         input trap_pkg::xlen_t mask);
        trap_pkg::cause_t num;
        num = '0;
        for (int i = 15; i >= 0; i--) begin
            if (lines[i] && mask[i + `TRAP_IRQ_LO]) begin
                num = trap_pkg::cause_t'(i + `TRAP_IRQ_LO);
            end
        end
        return num;
    endfunction

    // Combinational read sampled one step after the address.
    task automatic read_csr(input trap_pkg::csr_addr_e addr, output trap_pkg::xlen_t data);
        csr_addr = addr;
        #1;
        data = csr_rdata;
    endtask

    task automatic expect_csr(input string what, input trap_pkg::csr_addr_e addr,
                              input trap_pkg::xlen_t exp);
        trap_pkg::xlen_t data;
        read_csr(addr, data);
        check_word(what, data, exp);
    endtask

    // Write lands at the next edge.
    task automatic write_csr(input trap_pkg::csr_addr_e addr, input trap_pkg::xlen_t data);
        csr_addr  = addr;
        csr_we    = 1'b1;
        csr_wdata = data;
        next_cycle();
        csr_we = 1'b0;
    endtask

    task automatic wait_redirect(input int limit, output logic seen);
        int n;
        n = 0;
        #1;
        while (redirect !== 1'b1 && n < limit) begin
            next_cycle();
            #1;
            n++;
        end
        seen = (redirect === 1'b1);
        if (!seen) begin
            $display("Timeout at %0t: no redirect within %0d cycles", $time, limit);
            timeout_errors++;
        end
    endtask

    // Redirect must stay low for the whole window.
    task automatic quiet_window(input string what);
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            #1;
            check_flag(what, redirect, 1'b0);
            next_cycle();
        end
    endtask

    task automatic reset_state();
        trap_pkg::xlen_t data;
        #1;
        check_flag("redirect after reset", redirect, 1'b0);
        expect_csr("mstatus", trap_pkg::CSR_MSTATUS, '0);
        expect_csr("mie", trap_pkg::CSR_MIE, '0);
        expect_csr("mtvec", trap_pkg::CSR_MTVEC, '0);
        expect_csr("mscratch", trap_pkg::CSR_MSCRATCH, '0);
        check_flag("mscratch rdonly", csr_rdonly, 1'b0);
        expect_csr("mepc", trap_pkg::CSR_MEPC, '0);
        expect_csr("mcause", trap_pkg::CSR_MCAUSE, '0);
        expect_csr("mip", trap_pkg::CSR_MIP, '0);
        expect_csr("misa", trap_pkg::CSR_MISA, `TRAP_MISA_VALUE);
        expect_csr("mhartid", trap_pkg::CSR_MHARTID, 32'd5);
        check_flag("mhartid rdonly", csr_rdonly, 1'b1);
        check_flag("mhartid exists", csr_exists, 1'b1);
        // 0x7c0 is not implemented.
        read_csr(trap_pkg::csr_addr_e'(12'h7c0), data);
        check_flag("unimplemented exists", csr_exists, 1'b0);
        check_word("unimplemented rdata", data, '0);
    endtask

    task automatic write_masks();
        trap_pkg::xlen_t v;
        v = $urandom;
        write_csr(trap_pkg::CSR_MSCRATCH, v);
        expect_csr("mscratch", trap_pkg::CSR_MSCRATCH, v);
        v = $urandom;
        write_csr(trap_pkg::CSR_MIE, v);
        expect_csr("mie", trap_pkg::CSR_MIE, v);
        v = $urandom;
        write_csr(trap_pkg::CSR_MTVEC, v);
        expect_csr("mtvec", trap_pkg::CSR_MTVEC, {v[31:2], 2'b00});
        v = $urandom;
        write_csr(trap_pkg::CSR_MEPC, v);
        expect_csr("mepc", trap_pkg::CSR_MEPC, {v[31:1], 1'b0});
        v = $urandom;
        write_csr(trap_pkg::CSR_MSTATUS, v);
        expect_csr("mstatus", trap_pkg::CSR_MSTATUS,
                   mstatus_word(v[`TRAP_MSTATUS_MIE_BIT], v[`TRAP_MSTATUS_MPIE_BIT]));
        write_csr(trap_pkg::CSR_MHARTID, $urandom);
        expect_csr("mhartid after write", trap_pkg::CSR_MHARTID, 32'd5);
    endtask

    task automatic sync_trap();
        trap_pkg::xlen_t       v;
        trap_pkg::trap_cause_t cause;
        v = $urandom;
        tvec_exp = {v[31:2], 2'b00};
        write_csr(trap_pkg::CSR_MTVEC, v);
        // MIE set and MPIE clear so both fields move at trap entry.
        write_csr(trap_pkg::CSR_MSTATUS, mstatus_word(1'b1, 1'b0));
        // One-cycle trap pulse.
        v = $urandom;
        cause = 4'($urandom);
        trap_valid = 1'b1;
        trap_cause = cause;
        trap_pc    = v;
        #1;
        check_flag("trap redirect", redirect, 1'b1);
        check_word("trap redirect_pc", redirect_pc, tvec_exp);
        next_cycle();
        trap_valid = 1'b0;
        mepc_exp   = {v[31:1], 1'b0};
        expect_csr("mepc after trap", trap_pkg::CSR_MEPC, mepc_exp);
        expect_csr("mcause after trap", trap_pkg::CSR_MCAUSE, {28'b0, cause});
        expect_csr("mstatus after trap", trap_pkg::CSR_MSTATUS, mstatus_word(1'b0, 1'b1));
    endtask

    task automatic mret_return();
        ret = 1'b1;
        #1;
        check_flag("ret redirect", redirect, 1'b1);
        check_word("ret redirect_pc", redirect_pc, mepc_exp);
        next_cycle();
        ret = 1'b0;
        expect_csr("mstatus after ret", trap_pkg::CSR_MSTATUS, mstatus_word(1'b1, 1'b1));
    endtask

    task automatic irq_priority();
        logic [15:0]     lines;
        trap_pkg::xlen_t mask;
        trap_pkg::xlen_t pc;
        int              k;
        logic            seen;
        lines = 16'($urandom);
        mask  = $urandom;
        // At least one raised line is enabled.
        k = $urandom_range(15, 0);
        lines[k] = 1'b1;
        mask[k + `TRAP_IRQ_LO] = 1'b1;
        // Global enable stays clear until the lines are latched.
        write_csr(trap_pkg::CSR_MSTATUS, '0);
        write_csr(trap_pkg::CSR_MIE, mask);
        irq = lines;
        next_cycle();
        next_cycle();
        expect_csr("mip", trap_pkg::CSR_MIP, {lines, 16'b0} & mask);
        pc = $urandom;
        insn_valid = 1'b1;
        insn_pc    = pc;
        write_csr(trap_pkg::CSR_MSTATUS, mstatus_word(1'b1, 1'b0));
        // MIE was still clear in the previous cycle.
        #1;
        check_flag("irq redirect in first MIE cycle", redirect, 1'b0);
        next_cycle();
        // Trap in the same cycle loses to the interrupt.
        trap_valid = 1'b1;
        trap_cause = 4'($urandom);
        trap_pc    = ~pc;
        wait_redirect(WAIT_LIMIT, seen);
        if (seen) begin
            check_word("irq redirect_pc", redirect_pc, tvec_exp);
        end
        next_cycle();
        insn_valid = 1'b0;
        trap_valid = 1'b0;
        irq        = '0;
        expect_csr("mcause after irq", trap_pkg::CSR_MCAUSE,
                   {1'b1, 26'b0, lowest_enabled(lines, mask)});
        expect_csr("mepc after irq", trap_pkg::CSR_MEPC, {pc[31:1], 1'b0});
        expect_csr("mstatus after irq", trap_pkg::CSR_MSTATUS, mstatus_word(1'b0, 1'b1));
    endtask

    task automatic masked_irq();
        logic [15:0] lines;
        lines = 16'($urandom) | 16'h0001;
        // All lines enabled with global enable clear.
        write_csr(trap_pkg::CSR_MIE, '1);
        write_csr(trap_pkg::CSR_MSTATUS, '0);
        irq        = lines;
        insn_valid = 1'b1;
        insn_pc    = $urandom;
        quiet_window("redirect with MIE clear");
        insn_valid = 1'b0;
        // Global enable set with only idle lines enabled.
        write_csr(trap_pkg::CSR_MIE, {~lines, 16'hffff});
        write_csr(trap_pkg::CSR_MSTATUS, mstatus_word(1'b1, 1'b0));
        insn_valid = 1'b1;
        quiet_window("redirect with no enabled line");
        insn_valid = 1'b0;
        irq        = '0;
    endtask

    initial begin
        void'($urandom(37082));
        value_errors   = 0;
        timeout_errors = 0;
        rst        = 1'b1;
        csr_addr   = trap_pkg::CSR_MSTATUS;
        csr_we     = 1'b0;
        csr_wdata  = '0;
        irq        = '0;
        insn_valid = 1'b0;
        insn_pc    = '0;
        trap_valid = 1'b0;
        trap_cause = '0;
        trap_pc    = '0;
        ret        = 1'b0;
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;
        reset_state();
        write_masks();
        sync_trap();
        mret_return();
        irq_priority();
        masked_irq();
        $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/trap_unit.sv ====
/*
 * Machine-mode trap and CSR unit, top level.
 * Connects the CSR file, interrupt prioritizer and trap dispatch
 * to plain ports for the core.
 */
`default_nettype none
`include "trap_settings.svh"

module trap_unit #(
    parameter trap_pkg::xlen_t hartid = '0
) (
    input  logic                             clk,
    input  logic                             rst,
    // CSR access.
    input  trap_pkg::csr_addr_e              csr_addr,
    input  logic                             csr_we,
    input  trap_pkg::xlen_t                  csr_wdata,
    output trap_pkg::xlen_t                  csr_rdata,
    output logic                             csr_exists,
    output logic                             csr_rdonly,
    // External interrupt lines.
    input  logic [`TRAP_IRQ_HI:`TRAP_IRQ_LO] irq,
    // Instruction that an interrupt would preempt.
    input  logic                             insn_valid,
    input  trap_pkg::xlen_t                  insn_pc,
    // Synchronous trap from the pipeline.
    input  logic                             trap_valid,
    input  trap_pkg::trap_cause_t            trap_cause,
    input  trap_pkg::xlen_t                  trap_pc,
    // MRET.
    input  logic                             ret,
    // Fetch redirect.
    output logic                             redirect,
    output trap_pkg::xlen_t                  redirect_pc
);

    csr_access_if csr_bus ();
    trap_csr_if   trap_bus ();

    // Selected interrupt number.
    trap_pkg::cause_t irq_cause;

    // Core side of the CSR access path.
    assign csr_bus.addr  = csr_addr;
    assign csr_bus.we    = csr_we;
    assign csr_bus.wdata = csr_wdata;
    assign csr_rdata     = csr_bus.rdata;
    assign csr_exists    = csr_bus.exists;
    assign csr_rdonly    = csr_bus.rdonly;

    csr_file #(
        .hartid (hartid)
    ) csr_file_i (
        .clk  (clk),
        .rst  (rst),
        .csr  (csr_bus.csr_side),
        .trap (trap_bus.csr_side)
    );

    irq_prioritizer irq_prioritizer_i (
        .clk         (clk),
        .irq         (irq),
        .mie_mask    (trap_bus.mie_mask),
        .irq_pending (trap_bus.irq_pending),
        .irq_cause   (irq_cause)
    );

    trap_dispatch trap_dispatch_i (
        .clk         (clk),
        .rst         (rst),
        .irq_cause   (irq_cause),
        .insn_valid  (insn_valid),
        .insn_pc     (insn_pc),
        .trap_valid  (trap_valid),
        .trap_cause  (trap_cause),
        .trap_pc     (trap_pc),
        .ret         (ret),
        .trap        (trap_bus.dispatch),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

`default_nettype wire

// ==== verilog/trap_dispatch.sv ====
/*
 * Trap dispatch.
 * Picks interrupt over synchronous trap, forwards MRET and drives
 * the fetch redirect.
 */
`default_nettype none

module trap_dispatch (
    input  logic                  clk,
    input  logic                  rst,
    input  trap_pkg::cause_t      irq_cause,
    input  logic                  insn_valid,
    input  trap_pkg::xlen_t       insn_pc,
    input  logic                  trap_valid,
    input  trap_pkg::trap_cause_t trap_cause,
    input  trap_pkg::xlen_t       trap_pc,
    input  logic                  ret,
    trap_csr_if.dispatch          trap,
    output logic                  redirect,
    output trap_pkg::xlen_t       redirect_pc
);

    // MIE as seen one cycle ago.
    logic p_mie;
    logic irq_take;

    always_ff @(posedge clk) begin
        if (rst) begin
            p_mie <= 1'b0;
        end else begin
            p_mie <= trap.mstatus_mie;
        end
    end

    // Interrupts need MIE held over two cycles and a valid instruction.
    assign irq_take = (irq_cause != '0) && trap.mstatus_mie && p_mie && insn_valid;

    always_comb begin
        if (irq_take) begin
            // Interrupt, resumes at the interrupted instruction.
            trap.exc_kind = trap_pkg::EXC_IRQ;
            trap.ex_cause = irq_cause;
            trap.ex_epc   = insn_pc;
        end else if (trap_valid) begin
            trap.exc_kind = trap_pkg::EXC_TRAP;
            trap.ex_cause = trap_pkg::cause_t'(trap_cause);
            trap.ex_epc   = trap_pc;
        end else begin
            trap.exc_kind = trap_pkg::EXC_NONE;
            trap.ex_cause = '0;
            trap.ex_epc   = '0;
        end
    end

    assign trap.ret = ret;

    // MRET goes to mepc, any trap entry to mtvec.
    assign redirect    = ret || (trap.exc_kind != trap_pkg::EXC_NONE);
    assign redirect_pc = ret ? trap.ret_epc : trap.tvec;

endmodule

`default_nettype wire

// ==== verilog/irq_prioritizer.sv ====
/*
 * External interrupt prioritizer.
 * Latches lines 31 to 16, masks them with mie and reports the lowest
 * pending, enabled interrupt number.
 */
`default_nettype none
`include "trap_settings.svh"

module irq_prioritizer (
    input  logic                                   clk,
    input  logic [`TRAP_IRQ_HI:`TRAP_IRQ_LO]       irq,
    input  trap_pkg::xlen_t                        mie_mask,
    output trap_pkg::xlen_t                        irq_pending,
    output trap_pkg::cause_t                       irq_cause
);

    trap_pkg::xlen_t irq_masked;

    // One cycle of latch latency, low lines always clear.
    always_ff @(posedge clk) begin
        irq_pending <= '0;
        irq_pending[`TRAP_IRQ_HI:`TRAP_IRQ_LO] <= irq;
    end

    assign irq_masked = irq_pending & mie_mask;

    // Scan downward so the lowest set number wins.
    // Zero means nothing pending.
    always_comb begin
        irq_cause = '0;
        for (int i = `TRAP_IRQ_HI; i >= `TRAP_IRQ_LO; i--) begin
            if (irq_masked[i]) begin
                irq_cause = trap_pkg::cause_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/csr_file.sv ====
/*
 * Machine-mode CSR file.
 * Holds the writable CSRs, decodes reads and applies updates from
 * CSR writes, taken traps and interrupts, and MRET.
 */
`default_nettype none
`include "trap_settings.svh"

module csr_file #(
    parameter trap_pkg::xlen_t hartid = '0
) (
    input  logic                  clk,
    input  logic                  rst,
    csr_access_if.csr_side        csr,
    trap_csr_if.csr_side          trap
);

    // mstatus interrupt enable and its saved copy.
    logic            mstatus_mie;
    logic            mstatus_mpie;
    // Per-interrupt enables.
    trap_pkg::xlen_t mie;
    // Trap vector, direct mode only.
    trap_pkg::xlen_t mtvec;
    trap_pkg::xlen_t mscratch;
    // Return address, bit 0 stays clear.
    trap_pkg::xlen_t mepc;
    // mcause split into interrupt flag and number.
    logic            mcause_int;
    trap_pkg::cause_t mcause_no;

    // Assembled read views.
    trap_pkg::xlen_t mstatus_word;
    trap_pkg::xlen_t mcause_word;
    trap_pkg::xlen_t mip_word;

    logic exc_taken;

    assign exc_taken = (trap.exc_kind != trap_pkg::EXC_NONE);

    always_comb begin
        mstatus_word = '0;
        mstatus_word[`TRAP_MSTATUS_MIE_BIT] = mstatus_mie;
        mstatus_word[`TRAP_MSTATUS_MPIE_BIT] = mstatus_mpie;
    end

    // Flag in the top bit, number in the low bits.
    assign mcause_word = {mcause_int, {(`TRAP_XLEN-1-`TRAP_CAUSE_W){1'b0}}, mcause_no};

    // Pending lines, visible only where enabled.
    assign mip_word = trap.irq_pending & mie;

    // To dispatcher and prioritizer.
    assign trap.ret_epc     = mepc;
    assign trap.tvec        = mtvec;
    assign trap.mie_mask    = mie;
    assign trap.mstatus_mie = mstatus_mie;

    // Read decode.
    always_comb begin
        csr.rdata  = '0;
        csr.exists = 1'b1;
        csr.rdonly = 1'b0;
        case (csr.addr)
            trap_pkg::CSR_MSTATUS:  csr.rdata = mstatus_word;
            trap_pkg::CSR_MISA:     csr.rdata = `TRAP_MISA_VALUE;
            trap_pkg::CSR_MIE:      csr.rdata = mie;
            trap_pkg::CSR_MTVEC:    csr.rdata = mtvec;
            trap_pkg::CSR_MIP:      csr.rdata = mip_word;
            trap_pkg::CSR_MSCRATCH: csr.rdata = mscratch;
            trap_pkg::CSR_MEPC:     csr.rdata = mepc;
            trap_pkg::CSR_MCAUSE:   csr.rdata = mcause_word;
            // No delegation, no trap value.
            trap_pkg::CSR_MEDELEG, trap_pkg::CSR_MIDELEG,
            trap_pkg::CSR_MSTATUSH, trap_pkg::CSR_MTVAL: csr.rdata = '0;
            // ID registers read zero.
            trap_pkg::CSR_MVENDORID, trap_pkg::CSR_MARCHID,
            trap_pkg::CSR_MIMPID, trap_pkg::CSR_MCONFIGPTR: csr.rdonly = 1'b1;
            trap_pkg::CSR_MHARTID: begin
                csr.rdata  = hartid;
                csr.rdonly = 1'b1;
            end
            default: csr.exists = 1'b0;
        endcase
    end

    // Updates: reset, then MRET, then trap entry, then plain write.
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie          <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause_int   <= 1'b0;
            mcause_no    <= '0;
        end else if (trap.ret) begin
            // Restore the enable saved at trap entry.
            mstatus_mie <= mstatus_mpie;
        end else if (exc_taken) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mepc         <= {trap.ex_epc[`TRAP_XLEN-1:1], 1'b0};
            mcause_int   <= (trap.exc_kind == trap_pkg::EXC_IRQ);
            mcause_no    <= trap.ex_cause;
        end else if (csr.we) begin
            case (csr.addr)
                trap_pkg::CSR_MSTATUS: begin
                    mstatus_mie  <= csr.wdata[`TRAP_MSTATUS_MIE_BIT];
                    mstatus_mpie <= csr.wdata[`TRAP_MSTATUS_MPIE_BIT];
                end
                trap_pkg::CSR_MIE:      mie <= csr.wdata;
                // Direct mode, low two bits forced to zero.
                trap_pkg::CSR_MTVEC:    mtvec <= {csr.wdata[`TRAP_XLEN-1:2], 2'b00};
                trap_pkg::CSR_MSCRATCH: mscratch <= csr.wdata;
                trap_pkg::CSR_MEPC:     mepc <= {csr.wdata[`TRAP_XLEN-1:1], 1'b0};
                trap_pkg::CSR_MCAUSE: begin
                    mcause_int <= csr.wdata[`TRAP_XLEN-1];
                    mcause_no  <= csr.wdata[`TRAP_CAUSE_W-1:0];
                end
                // Constant and read-only CSRs ignore writes.
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/trap_if.sv ====
/*
 * Trap unit internal interfaces.
 * csr_access_if carries CSR reads and writes from the core side.
 * trap_csr_if links the dispatcher, the prioritizer and the CSR file.
 */
`default_nettype none

interface csr_access_if;
    // Access address.
    trap_pkg::csr_addr_e addr;
    // Write strobe and data.
    logic                we;
    trap_pkg::xlen_t     wdata;
    // Read data, zero for unknown addresses.
    trap_pkg::xlen_t     rdata;
    // Address decodes to an implemented CSR.
    logic                exists;
    // CSR ignores writes.
    logic                rdonly;

    // Core side issues accesses.
    modport host (output addr, we, wdata, input rdata, exists, rdonly);
    // CSR file answers them.
    modport csr_side (input addr, we, wdata, output rdata, exists, rdonly);
endinterface

interface trap_csr_if;
    // Event chosen by the dispatcher.
    trap_pkg::exc_kind_e exc_kind;
    trap_pkg::cause_t    ex_cause;
    trap_pkg::xlen_t     ex_epc;
    // MRET strobe.
    logic                ret;
    // Return and trap targets.
    trap_pkg::xlen_t     ret_epc;
    trap_pkg::xlen_t     tvec;
    // Interrupt enables, feeds the prioritizer.
    trap_pkg::xlen_t     mie_mask;
    // Latched external lines, driven by the prioritizer.
    trap_pkg::xlen_t     irq_pending;
    // Global machine interrupt enable.
    logic                mstatus_mie;

    modport csr_side (
        input  exc_kind, ex_cause, ex_epc, ret, irq_pending,
        output ret_epc, tvec, mie_mask, mstatus_mie
    );
    modport dispatch (
        output exc_kind, ex_cause, ex_epc, ret,
        input  ret_epc, tvec, mstatus_mie
    );
endinterface

`default_nettype wire

// ==== verilog/trap_pkg.sv ====
/*
 * Trap unit package.
 * Data, cause and CSR address types shared by the trap unit blocks.
 */
`default_nettype none
`include "trap_settings.svh"

package trap_pkg;

    // One data word.
    typedef logic [`TRAP_XLEN-1:0] xlen_t;

    // Stored cause number, interrupt or exception.
    typedef logic [`TRAP_CAUSE_W-1:0] cause_t;

    // Synchronous cause as reported by the pipeline.
    typedef logic [3:0] trap_cause_t;

    // Implemented CSR addresses.
    typedef enum logic [11:0] {
        CSR_MSTATUS    = `TRAP_CSR_MSTATUS,
        CSR_MISA       = `TRAP_CSR_MISA,
        CSR_MEDELEG    = `TRAP_CSR_MEDELEG,
        CSR_MIDELEG    = `TRAP_CSR_MIDELEG,
        CSR_MIE        = `TRAP_CSR_MIE,
        CSR_MTVEC      = `TRAP_CSR_MTVEC,
        CSR_MSTATUSH   = `TRAP_CSR_MSTATUSH,
        CSR_MSCRATCH   = `TRAP_CSR_MSCRATCH,
        CSR_MEPC       = `TRAP_CSR_MEPC,
        CSR_MCAUSE     = `TRAP_CSR_MCAUSE,
        CSR_MTVAL      = `TRAP_CSR_MTVAL,
        CSR_MIP        = `TRAP_CSR_MIP,
        CSR_MVENDORID  = `TRAP_CSR_MVENDORID,
        CSR_MARCHID    = `TRAP_CSR_MARCHID,
        CSR_MIMPID     = `TRAP_CSR_MIMPID,
        CSR_MHARTID    = `TRAP_CSR_MHARTID,
        CSR_MCONFIGPTR = `TRAP_CSR_MCONFIGPTR
    } csr_addr_e;

    // Event taken by the dispatcher this cycle.
    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_IRQ,
        EXC_TRAP
    } exc_kind_e;

endpackage

`default_nettype wire

// ==== verilog/trap_settings.svh ====
/*
 * Trap unit settings.
 * Data width, CSR addresses, interrupt range and constant CSR values
 * of the machine-mode trap and CSR unit.
 */
`ifndef TRAP_SETTINGS_SVH
`define TRAP_SETTINGS_SVH

// Data path.
`define TRAP_XLEN    32
`define TRAP_CAUSE_W 5

// External interrupt numbers.
`define TRAP_IRQ_LO 16
`define TRAP_IRQ_HI 31

// RV32IM: MXL=1, I and M extension bits.
`define TRAP_MISA_VALUE 32'h4000_1100

// mstatus field positions.
`define TRAP_MSTATUS_MIE_BIT  3
`define TRAP_MSTATUS_MPIE_BIT 7

// Machine-mode CSR addresses.
`define TRAP_CSR_MSTATUS    12'h300
`define TRAP_CSR_MISA       12'h301
`define TRAP_CSR_MEDELEG    12'h302
`define TRAP_CSR_MIDELEG    12'h303
`define TRAP_CSR_MIE        12'h304
`define TRAP_CSR_MTVEC      12'h305
`define TRAP_CSR_MSTATUSH   12'h310
`define TRAP_CSR_MSCRATCH   12'h340
`define TRAP_CSR_MEPC       12'h341
`define TRAP_CSR_MCAUSE     12'h342
`define TRAP_CSR_MTVAL      12'h343
`define TRAP_CSR_MIP        12'h344
`define TRAP_CSR_MVENDORID  12'hf11
`define TRAP_CSR_MARCHID    12'hf12
`define TRAP_CSR_MIMPID     12'hf13
`define TRAP_CSR_MHARTID    12'hf14
`define TRAP_CSR_MCONFIGPTR 12'hf15

`endif
